// ==== logic/tcb_pkg.sv ====
//////////////////////////////////////////////////
// tcb bus types and constants
// byte lanes only, at most TCB_MAX_LANES per word
// status is a single bit, misalignment is the only error
//////////////////////////////////////////////////

`default_nettype none

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  // bits per byte lane
  localparam int unsigned TCB_UNT_W = 8;

  // widest word the types below can describe
  localparam int unsigned TCB_MAX_LANES = 8;

  // offset field, one bit wider than the widest lane index
  localparam int unsigned TCB_OFF_W = $clog2(TCB_MAX_LANES) + 1;

  //////////////////////////////////////////////////
  // transfer size
  //////////////////////////////////////////////////

  // size code s means 2**s bytes
  typedef logic [1:0] tcb_siz_t;

  localparam tcb_siz_t TCB_SIZ_1 = 2'd0;
  localparam tcb_siz_t TCB_SIZ_2 = 2'd1;
  localparam tcb_siz_t TCB_SIZ_4 = 2'd2;
  localparam tcb_siz_t TCB_SIZ_8 = 2'd3;

  //////////////////////////////////////////////////
  // response status
  //////////////////////////////////////////////////

  localparam logic TCB_STS_OK  = 1'b0;
  localparam logic TCB_STS_MAL = 1'b1;

  // lane steering, stored whole in the response delay line
  typedef struct packed {
    logic [TCB_OFF_W-1:0] off;  // byte offset within the word
    tcb_siz_t             siz;  // size code
    logic                 ndn;  // 0 little, 1 big endian
  } tcb_sel_t;

endpackage : tcb_pkg

`default_nettype wire

// ==== logic/tcb_converter.sv ====
//////////////////////////////////////////////////
// reference to memory mode converter, combinational
// misaligned accesses are flagged and not forwarded
// siz must not exceed the word, lanes are descending
// read data is realigned with the delayed steering
//////////////////////////////////////////////////

`default_nettype none

module tcb_converter #(
  parameter int unsigned DAT_W = 32,
  parameter int unsigned ADR_W = 10
) (
  // manager request, reference mode
  input  wire logic                                   vld,
  input  wire logic                                   wen,
  input  wire logic                                   ndn,
  input  wire tcb_pkg::tcb_siz_t                      siz,
  input  wire logic [ADR_W-1:0]                       adr,
  input  wire logic [DAT_W-1:0]                       wdt,
  output logic                                        mal,
  // memory side
  input  wire logic                                   rdy,
  output logic                                        mem_vld,
  output logic                                        mem_wen,
  output logic [ADR_W-$clog2(DAT_W/8)-1:0]            mem_adr,
  output logic [DAT_W/8-1:0]                          mem_ben,
  output logic [DAT_W-1:0]                            mem_wdt,
  input  wire logic [DAT_W-1:0]                       mem_rdt,
  // delay line side
  output logic                                        trn,
  output tcb_pkg::tcb_sel_t                           req_sel,
  output logic                                        req_sts,
  input  wire tcb_pkg::tcb_sel_t                      rsp_sel,
  // realigned read data
  output logic [DAT_W-1:0]                            rdt
);

  import tcb_pkg::*;

  localparam int unsigned LANES = DAT_W / TCB_UNT_W;
  localparam int unsigned OFF_W = $clog2(LANES);

  // request offset and last byte index
  logic [OFF_W-1:0] req_off;
  logic [OFF_W-1:0] req_lst;
  // same pair, delayed to the response
  logic [OFF_W-1:0] rsp_off;
  logic [OFF_W-1:0] rsp_lst;

  // lane views of the data words
  logic [LANES-1:0][TCB_UNT_W-1:0] wdt_lan;
  logic [LANES-1:0][TCB_UNT_W-1:0] mem_wdt_lan;
  logic [LANES-1:0][TCB_UNT_W-1:0] mem_rdt_lan;
  logic [LANES-1:0][TCB_UNT_W-1:0] rdt_lan;

  // per lane multiplexer selects
  logic [OFF_W-1:0] sel_wdt [LANES];
  logic [OFF_W-1:0] sel_rdt [LANES];

  //////////////////////////////////////////////////
  // alignment
  //////////////////////////////////////////////////

  // low address bits must be zero for the size
  always_comb begin
    unique case (siz)
      TCB_SIZ_1: mal = 1'b0;
      TCB_SIZ_2: mal = adr[0];
      TCB_SIZ_4: mal = |adr[1:0];
      TCB_SIZ_8: mal = |adr[2:0];
    endcase
  end

  assign req_off = adr[OFF_W-1:0];
  // bytes minus one, wraps only for illegal sizes
  assign req_lst = OFF_W'((1 << siz) - 1);

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // misaligned accesses stop here
  assign mem_vld = vld & ~mal;
  assign mem_wen = wen;
  // word address, offset dropped
  assign mem_adr = adr[ADR_W-1:OFF_W];

  assign wdt_lan = wdt;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      // lane i holds value byte i-off, or off+lst-i when big endian
      if (ndn) begin
        sel_wdt[i] = req_off + req_lst - OFF_W'(i);
      end else begin
        sel_wdt[i] = OFF_W'(i) - req_off;
      end
      // contiguous enables from off to off+lst
      mem_ben[i]     = (OFF_W'(i) - req_off) <= req_lst;
      mem_wdt_lan[i] = wdt_lan[sel_wdt[i]];
    end
  end

  assign mem_wdt = mem_wdt_lan;

  //////////////////////////////////////////////////
  // steering for the delay line
  //////////////////////////////////////////////////

  // every handshake, misaligned included
  assign trn = vld & rdy;

  always_comb begin
    req_sel.off = TCB_OFF_W'(req_off);
    req_sel.siz = siz;
    req_sel.ndn = ndn;
  end

  assign req_sts = mal ? TCB_STS_MAL : TCB_STS_OK;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  assign rsp_off     = rsp_sel.off[OFF_W-1:0];
  assign rsp_lst     = OFF_W'((1 << rsp_sel.siz) - 1);
  assign mem_rdt_lan = mem_rdt;

  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      // inverse of the write rule
      if (rsp_sel.ndn) begin
        sel_rdt[k] = rsp_off + rsp_lst - OFF_W'(k);
      end else begin
        sel_rdt[k] = rsp_off + OFF_W'(k);
      end
      // bytes above the size read as zero
      if (OFF_W'(k) <= rsp_lst) begin
        rdt_lan[k] = mem_rdt_lan[sel_rdt[k]];
      end else begin
        rdt_lan[k] = '0;
      end
    end
  end

  assign rdt = rdt_lan;

  //////////////////////////////////////////////////
  // manager contract
  //////////////////////////////////////////////////

  always_comb begin
    if (vld) begin
      // an access never crosses a word
      siz_fits : assert final ((1 << siz) <= LANES)
        else $error("transfer size %0d exceeds %0d lanes", siz, LANES);
      adr_known : assert final (!$isunknown(adr))
        else $error("unknown address while vld is high");
    end
  end

endmodule : tcb_converter

`default_nettype wire

// ==== logic/tcb_rsp_delay.sv ====
//////////////////////////////////////////////////
// response delay line, RD_DLY stages
// one transfer per cycle, RD_DLY of them in flight
// only the valid bits are reset
//////////////////////////////////////////////////

`default_nettype none

module tcb_rsp_delay #(
  parameter int unsigned RD_DLY = 2
) (
  input  wire logic              clk,
  input  wire logic              arst_n,
  // request side
  input  wire logic              trn,
  input  wire tcb_pkg::tcb_sel_t req_sel,
  input  wire logic              req_sts,
  // response side
  output logic                   rsp_vld,
  output tcb_pkg::tcb_sel_t      rsp_sel,
  output logic                   sts
);

  import tcb_pkg::*;

  // stage 0 is loaded by the transfer, last stage is the response
  logic     vld_q [RD_DLY];
  tcb_sel_t sel_q [RD_DLY];
  logic     sts_q [RD_DLY];

  //////////////////////////////////////////////////
  // valid chain
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < RD_DLY; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= trn;
      for (int i = 1; i < RD_DLY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  //////////////////////////////////////////////////
  // steering and status chain
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    // idle cycles keep the old payload, it is never used
    if (trn) begin
      sel_q[0] <= req_sel;
      sts_q[0] <= req_sts;
    end
    for (int i = 1; i < RD_DLY; i++) begin
      sel_q[i] <= sel_q[i-1];
      sts_q[i] <= sts_q[i-1];
    end
  end

  assign rsp_vld = vld_q[RD_DLY-1];
  assign rsp_sel = sel_q[RD_DLY-1];
  assign sts     = sts_q[RD_DLY-1];

  // response lines up with the memory read latency
  rsp_after_trn : assert property (@(posedge clk) disable iff (!arst_n)
    trn |-> ##RD_DLY rsp_vld)
    else $error("no response %0d cycles after transfer", RD_DLY);

  rsp_has_trn : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> $past(trn, RD_DLY))
    else $error("response without a transfer %0d cycles earlier", RD_DLY);

endmodule : tcb_rsp_delay

`default_nettype wire

// ==== logic/tcb_memory.sv ====
//////////////////////////////////////////////////
// byte enable memory, descending lanes
// fixed read latency RD_DLY, 1 to 3 cycles
// rdy rises one cycle after reset and stays high
// contents are not initialized
//////////////////////////////////////////////////

`default_nettype none

module tcb_memory #(
  parameter int unsigned DAT_W  = 32,
  parameter int unsigned ADR_W  = 10,
  parameter int unsigned RD_DLY = 2
) (
  input  wire logic                              clk,
  input  wire logic                              arst_n,
  // request
  input  wire logic                              mem_vld,
  input  wire logic                              mem_wen,
  input  wire logic [ADR_W-$clog2(DAT_W/8)-1:0]  mem_adr,
  input  wire logic [DAT_W/8-1:0]                mem_ben,
  input  wire logic [DAT_W-1:0]                  mem_wdt,
  output logic                                   rdy,
  // response
  output logic [DAT_W-1:0]                       mem_rdt
);

  import tcb_pkg::*;

  localparam int unsigned LANES = DAT_W / TCB_UNT_W;
  localparam int unsigned WRD_W = ADR_W - $clog2(LANES);
  localparam int unsigned DEPTH = 2 ** WRD_W;

  // storage, one word per address
  logic [LANES-1:0][TCB_UNT_W-1:0] mem [DEPTH];
  logic [LANES-1:0][TCB_UNT_W-1:0] wdt_lan;

  // read data pipeline
  logic [DAT_W-1:0] rdt_q [RD_DLY];

  // accepted write and read
  logic wr;
  logic rd;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // no back-pressure after reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign wr = mem_vld & rdy & mem_wen;
  assign rd = mem_vld & rdy & ~mem_wen;

  //////////////////////////////////////////////////
  // array
  //////////////////////////////////////////////////

  assign wdt_lan = mem_wdt;

  // per byte write
  always_ff @(posedge clk) begin
    if (wr) begin
      for (int i = 0; i < LANES; i++) begin
        if (mem_ben[i]) begin
          mem[mem_adr][i] <= wdt_lan[i];
        end
      end
    end
  end

  // read, then RD_DLY-1 more stages
  always_ff @(posedge clk) begin
    if (rd) begin
      rdt_q[0] <= mem[mem_adr];
    end
    for (int i = 1; i < RD_DLY; i++) begin
      rdt_q[i] <= rdt_q[i-1];
    end
  end

  assign mem_rdt = rdt_q[RD_DLY-1];

  // converter never sends an empty lane mask
  ben_nonzero : assert property (@(posedge clk) disable iff (!arst_n)
    mem_vld && rdy |-> mem_ben != '0)
    else $error("accepted access with no byte enabled");

endmodule : tcb_memory

`default_nettype wire

// ==== logic/tcb_subsystem_top.sv ====
//////////////////////////////////////////////////
// converter, response delay line and memory
// DAT_W 32 or 64, RD_DLY 1 to 3
// responses come RD_DLY cycles after each transfer
//////////////////////////////////////////////////

`default_nettype none

module tcb_subsystem_top #(
  parameter int unsigned DAT_W  = 32,
  parameter int unsigned ADR_W  = 10,
  parameter int unsigned RD_DLY = 2
) (
  input  wire logic              clk,
  input  wire logic              arst_n,
  // manager request
  input  wire logic              vld,
  input  wire logic              wen,
  input  wire logic              ndn,
  input  wire tcb_pkg::tcb_siz_t siz,
  input  wire logic [ADR_W-1:0]  adr,
  input  wire logic [DAT_W-1:0]  wdt,
  output logic                   rdy,
  output logic                   mal,
  // manager response
  output logic                   rsp_vld,
  output logic [DAT_W-1:0]       rdt,
  output logic                   sts
);

  import tcb_pkg::*;

  localparam int unsigned LANES = DAT_W / TCB_UNT_W;
  localparam int unsigned WRD_W = ADR_W - $clog2(LANES);

  // converter to memory
  logic                 mem_vld;
  logic                 mem_wen;
  logic [WRD_W-1:0]     mem_adr;
  logic [LANES-1:0]     mem_ben;
  logic [DAT_W-1:0]     mem_wdt;
  logic [DAT_W-1:0]     mem_rdt;

  // converter to and from the delay line
  logic                 trn;
  tcb_sel_t             req_sel;
  logic                 req_sts;
  tcb_sel_t             rsp_sel;

  // port names match the wires above
  tcb_converter #(
    .DAT_W (DAT_W),
    .ADR_W (ADR_W)
  ) tcb_converter_i (.*);

  tcb_rsp_delay #(
    .RD_DLY (RD_DLY)
  ) tcb_rsp_delay_i (.*);

  tcb_memory #(
    .DAT_W  (DAT_W),
    .ADR_W  (ADR_W),
    .RD_DLY (RD_DLY)
  ) tcb_memory_i (.*);

endmodule : tcb_subsystem_top

`default_nettype wire

// ==== testbench/tcb_subsystem_tb.sv ====
//////////////////////////////////////////////////
// testbench for the tcb subsystem, DAT_W 32, RD_DLY 2
// the whole memory is written first, reads never hit X
// concurrent assertions do all of the checking
//////////////////////////////////////////////////

`default_nettype none

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int unsigned DAT_W   = 32;
  localparam int unsigned ADR_W   = 10;
  localparam int unsigned RD_DLY  = 2;
  localparam int unsigned LANES   = DAT_W / 8;
  localparam int unsigned MAX_SIZ = $clog2(LANES);
  localparam int unsigned WORDS   = (2 ** ADR_W) / LANES;

  localparam int unsigned CLK_PER = 40;
  localparam int unsigned DRV_DLY = 5;
  localparam int unsigned RST_CYC = 8;

  // transfers per phase, and the run limit they give
  localparam int unsigned N_RW      = 48;
  localparam int unsigned N_BE      = 48;
  localparam int unsigned N_MAL     = 24;
  localparam int unsigned N_MIX     = 160;
  localparam int unsigned N_XFER    = WORDS + 2 * N_RW + N_BE + 3 * N_MAL + N_MIX;
  localparam int unsigned CYC_LIMIT = 2 * N_XFER + RST_CYC + 64;

  logic             clk;
  logic             arst_n;
  logic             vld;
  logic             wen;
  logic             ndn;
  tcb_siz_t         siz;
  logic [ADR_W-1:0] adr;
  logic [DAT_W-1:0] wdt;
  logic             rdy;
  logic             mal;
  logic             rsp_vld;
  logic [DAT_W-1:0] rdt;
  logic             sts;

  logic [31:0]      rng;
  int unsigned      cycles = 0;

  // byte addressed reference memory
  logic [7:0]       ref_mem [2 ** ADR_W];

  // outstanding responses, oldest first
  logic [DAT_W-1:0] exp_rdt_q [$];
  logic             exp_sts_q [$];
  logic             exp_chk_q [$];

  // head of the queue, what the next response must show
  logic             head_vld;
  logic [DAT_W-1:0] head_rdt;
  logic             head_sts;
  logic             head_chk;

  logic             exp_mal;

  tcb_subsystem_top #(
    .DAT_W  (DAT_W),
    .ADR_W  (ADR_W),
    .RD_DLY (RD_DLY)
  ) tcb_subsystem_top_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .wen     (wen),
    .ndn     (ndn),
    .siz     (siz),
    .adr     (adr),
    .wdt     (wdt),
    .rdy     (rdy),
    .mal     (mal),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .sts     (sts)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  task automatic next_word(output logic [DAT_W-1:0] w);
    for (int i = 0; i < DAT_W; i += 32) begin
      rng      = xorshift32(rng);
      w[i+:32] = rng;
    end
  endtask

  // low address bits that must be zero for size s
  function automatic logic [ADR_W-1:0] size_mask(input tcb_siz_t s);
    return ADR_W'((32'd1 << s) - 32'd1);
  endfunction

  function automatic logic is_misaligned(input logic [ADR_W-1:0] a, input tcb_siz_t s);
    return (a & size_mask(s)) != '0;
  endfunction

  // address of value byte k, big endian counts down from the top
  function automatic logic [ADR_W-1:0] byte_adr(input logic [ADR_W-1:0] a,
                                                input tcb_siz_t s, input logic e, input int k);
    int n;
    n = 1 << s;
    if (e) begin
      return a + ADR_W'(n - 1 - k);
    end else begin
      return a + ADR_W'(k);
    end
  endfunction

  task automatic model_write(input logic [ADR_W-1:0] a, input tcb_siz_t s, input logic e,
                             input logic [DAT_W-1:0] d);
    for (int k = 0; k < (1 << s); k++) begin
      ref_mem[byte_adr(a, s, e, k)] = d[8*k+:8];
    end
  endtask

  // bytes above the size stay zero
  function automatic logic [DAT_W-1:0] model_read(input logic [ADR_W-1:0] a,
                                                  input tcb_siz_t s, input logic e);
    logic [DAT_W-1:0] r;
    r = '0;
    for (int k = 0; k < (1 << s); k++) begin
      r[8*k+:8] = ref_mem[byte_adr(a, s, e, k)];
    end
    return r;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [DAT_W-1:0] got,
                                 input logic [DAT_W-1:0] exp);
    abort_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic expect_rsp(input logic [DAT_W-1:0] d, input logic st, input logic chk);
    exp_rdt_q.push_back(d);
    exp_sts_q.push_back(st);
    exp_chk_q.push_back(chk);
  endtask

  // holds the request until the edge that takes it
  task automatic issue_xfer(input logic w, input logic e, input tcb_siz_t s,
                            input logic [ADR_W-1:0] a, input logic [DAT_W-1:0] d);
    logic taken;
    vld   = 1'b1;
    wen   = w;
    ndn   = e;
    siz   = s;
    adr   = a;
    wdt   = d;
    taken = 1'b0;
    while (!taken) begin
      taken = rdy;
      @(posedge clk);
      #DRV_DLY;
    end
  endtask

  task automatic rand_siz(input int unsigned lo, output tcb_siz_t s);
    logic [31:0] r;
    next_rand(r);
    s = tcb_siz_t'(lo + r % (MAX_SIZ + 1 - lo));
  endtask

  task automatic rand_aligned(input tcb_siz_t s, output logic [ADR_W-1:0] a);
    logic [31:0] r;
    next_rand(r);
    a = ADR_W'(r) & ~size_mask(s);
  endtask

  //////////////////////////////////////////////////
  // reference model and response queue
  //////////////////////////////////////////////////

  assign exp_mal = is_misaligned(adr, siz);

  always @(posedge clk) begin
    if (!arst_n) begin
      head_vld <= 1'b0;
    end else begin
      if (rsp_vld && exp_sts_q.size() != 0) begin
        void'(exp_rdt_q.pop_front());
        void'(exp_sts_q.pop_front());
        void'(exp_chk_q.pop_front());
      end
      if (vld && rdy) begin
        if (is_misaligned(adr, siz)) begin
          // never reaches memory, data is not checked
          expect_rsp('0, TCB_STS_MAL, 1'b0);
        end else if (wen) begin
          model_write(adr, siz, ndn, wdt);
          expect_rsp('0, TCB_STS_OK, 1'b0);
        end else begin
          expect_rsp(model_read(adr, siz, ndn), TCB_STS_OK, 1'b1);
        end
      end
      if (exp_sts_q.size() != 0) begin
        head_vld <= 1'b1;
        head_rdt <= exp_rdt_q[0];
        head_sts <= exp_sts_q[0];
        head_chk <= exp_chk_q[0];
      end else begin
        head_vld <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYC_LIMIT) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", CYC_LIMIT));
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  rdy_in_reset : assert property (@(posedge clk) !arst_n |-> !rdy)
    else report_mismatch("rdy", DAT_W'($sampled(rdy)), '0);

  rsp_in_reset : assert property (@(posedge clk) !arst_n |-> !rsp_vld)
    else report_mismatch("rsp_vld", DAT_W'($sampled(rsp_vld)), '0);

  // high from the first edge after release, then never low
  rdy_after_reset : assert property (@(posedge clk) disable iff (!arst_n)
    $past(arst_n) |-> rdy)
    else report_mismatch("rdy", DAT_W'($sampled(rdy)), DAT_W'(1));

  mal_same_cycle : assert property (@(posedge clk) disable iff (!arst_n)
    vld |-> mal == exp_mal)
    else report_mismatch("mal", DAT_W'($sampled(mal)), DAT_W'($sampled(exp_mal)));

  rsp_on_time : assert property (@(posedge clk) disable iff (!arst_n)
    vld && rdy |-> ##RD_DLY rsp_vld)
    else abort_run("a transfer got no response after the read latency");

  rsp_from_xfer : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> $past(vld && rdy, RD_DLY))
    else abort_run("a response came without a transfer one read latency earlier");

  rsp_expected : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> head_vld)
    else abort_run("a response came while no transfer was outstanding");

  sts_correct : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld |-> sts == head_sts)
    else report_mismatch("sts", DAT_W'($sampled(sts)), DAT_W'($sampled(head_sts)));

  rdt_correct : assert property (@(posedge clk) disable iff (!arst_n)
    rsp_vld && head_chk |-> rdt == head_rdt)
    else report_mismatch("rdt", $sampled(rdt), $sampled(head_rdt));

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]      r;
    logic [ADR_W-1:0] a;
    logic [DAT_W-1:0] d;
    tcb_siz_t         s;
    arst_n = 1'b0;
    vld    = 1'b0;
    wen    = 1'b0;
    ndn    = 1'b0;
    siz    = '0;
    adr    = '0;
    wdt    = '0;
    rng    = 32'he42d;
    repeat (RST_CYC) @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b1;
    @(posedge clk);
    #DRV_DLY;

    // fill, full words little endian
    for (int w = 0; w < WORDS; w++) begin
      next_word(d);
      issue_xfer(1'b1, 1'b0, tcb_siz_t'(MAX_SIZ), ADR_W'(w * LANES), d);
    end

    // write then read back, every size
    repeat (N_RW) begin
      rand_siz(0, s);
      rand_aligned(s, a);
      next_word(d);
      issue_xfer(1'b1, 1'b0, s, a, d);
      issue_xfer(1'b0, 1'b0, s, a, '0);
    end

    // burst of big endian reads on consecutive cycles
    repeat (N_BE) begin
      rand_siz(0, s);
      rand_aligned(s, a);
      issue_xfer(1'b0, 1'b1, s, a, '0);
    end

    // misaligned write and read, then the whole word
    repeat (N_MAL) begin
      rand_siz(1, s);
      rand_aligned(s, a);
      next_rand(r);
      // nonzero offset below the size
      a = a + ADR_W'(1 + r % ((32'd1 << s) - 32'd1));
      next_word(d);
      issue_xfer(1'b1, r[31], s, a, d);
      issue_xfer(1'b0, r[30], s, a, '0);
      issue_xfer(1'b0, 1'b0, tcb_siz_t'(MAX_SIZ), a & ~size_mask(tcb_siz_t'(MAX_SIZ)), '0);
    end

    // mixed traffic, both endians
    repeat (N_MIX) begin
      rand_siz(0, s);
      rand_aligned(s, a);
      next_word(d);
      next_rand(r);
      issue_xfer(r[0], r[1], s, a, d);
    end

    vld = 1'b0;
    // drain what is still in flight
    while (exp_sts_q.size() != 0) begin
      @(posedge clk);
      #DRV_DLY;
    end
    @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule : tcb_subsystem_tb

`default_nettype wire

// ==== vlog.f ====
logic/tcb_pkg.sv
logic/tcb_converter.sv
logic/tcb_rsp_delay.sv
logic/tcb_memory.sv
logic/tcb_subsystem_top.sv
testbench/tcb_subsystem_tb.sv

// ==== sim.sh ====
#!/usr/bin/env bash
# build and run the tcb subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tcb_subsystem_tb \
  -f vlog.f

# $fatal gives a nonzero exit, the search below decides the result
out="$(./obj_dir/Vtcb_subsystem_tb 2>&1)" || true
echo "$out"

if grep -qx "All tests passed" <<< "$out"; then
  exit 0
fi
exit 1
